/* epb_opb_defines.svh */
`ifndef EPB_OPB_DEFINES_SVH
`define EPB_OPB_DEFINES_SVH

// opb data and address width
`define EPB_OPB_DATA_W 32

// number of register slaves behind the bridge
`define EPB_OPB_NUM_SLAVES 4

// 32-bit registers in each slave
`define EPB_OPB_SLAVE_WORDS 8

// lowest byte-address bit of the slave index field
`define EPB_OPB_SLAVE_IDX_LSB 5

`endif

/* epb_opb_pkg.sv */
`include "epb_opb_defines.svh"

package epb_opb_pkg;

  // request from the master, all zero while select is low
  typedef struct packed {
    logic                       select;
    logic                       rnw;   // read when high
    logic [3:0]                 be;    // bit 3 is the msb byte
    logic [`EPB_OPB_DATA_W-1:0] abus;  // byte address
    logic [`EPB_OPB_DATA_W-1:0] dbus;  // write data
  } opb_req_t;

  // reply from a slave or the merger
  typedef struct packed {
    logic                       xfer_ack;
    logic                       err_ack;
    logic [`EPB_OPB_DATA_W-1:0] dbus;  // zero unless a read is acked
  } opb_rsp_t;

  // host pins as captured on each clock edge
  typedef struct packed {
    logic        cs_n;
    logic        oe_n;
    logic        r_w_n;
    logic [1:0]  be_n;
    logic [22:0] addr;     // halfword address
    logic [5:0]  addr_gp;  // address extension
    logic [15:0] data;
  } epb_sample_t;

endpackage

/* epb_opb_bridge.sv */
module epb_opb_bridge (
  input  logic                   OPB_Clk,
  input  logic                   arst_n,
  input  logic                   epb_cs_n,
  input  logic                   epb_oe_n,
  input  logic                   epb_r_w_n,
  input  logic [1:0]             epb_be_n,
  input  logic [22:0]            epb_addr,
  input  logic [5:0]             epb_addr_gp,
  input  logic [15:0]            epb_data_i,
  output logic [15:0]            epb_data_o,
  output logic                   epb_data_oe_n,
  output logic                   epb_rdy,
  output epb_opb_pkg::opb_req_t  opb_req,
  input  epb_opb_pkg::opb_rsp_t  opb_rsp
);
  import epb_opb_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_WAIT
  } state_t;

  epb_sample_t smp;      // registered host pins
  logic        prev_cs_n;
  state_t      state;
  logic        select_q;
  logic        start;
  logic        in_access;
  logic        reply;
  logic        rdy_int;
  logic [1:0]  lane_be;
  logic [15:0] rd_half;

  // every pin is captured on every edge
  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      smp.cs_n    <= 1'b1;
      smp.oe_n    <= 1'b1;
      smp.r_w_n   <= 1'b1;
      smp.be_n    <= 2'b11;
      smp.addr    <= '0;
      smp.addr_gp <= '0;
      smp.data    <= '0;
      prev_cs_n   <= 1'b1;
    end else begin
      smp.cs_n    <= epb_cs_n;
      smp.oe_n    <= epb_oe_n;
      smp.r_w_n   <= epb_r_w_n;
      smp.be_n    <= epb_be_n;
      smp.addr    <= epb_addr;
      smp.addr_gp <= epb_addr_gp;
      smp.data    <= epb_data_i;
      prev_cs_n   <= smp.cs_n;
    end
  end

  assign in_access = ~smp.cs_n;
  assign start     = prev_cs_n & ~smp.cs_n;  // falling edge of sampled cs_n
  assign reply     = opb_rsp.xfer_ack | opb_rsp.err_ack;

  // bridge drives the data pins only for a selected read with oe_n low
  assign epb_data_oe_n = smp.cs_n | ~smp.r_w_n | smp.oe_n;

  // reads take both bytes of the lane
  assign lane_be = smp.r_w_n ? 2'b11 : ~smp.be_n;

  always_comb begin
    opb_req = '0;
    if (select_q || (state == ST_IDLE && start)) begin
      opb_req.select = 1'b1;  // cut through on the start cycle
      opb_req.rnw    = smp.r_w_n;
      opb_req.abus   = {5'b0, smp.addr_gp[2:0], smp.addr[22:1], 2'b0};
      if (smp.addr[0]) begin  // low halfword
        opb_req.be   = {2'b00, lane_be};
        opb_req.dbus = smp.r_w_n ? '0 : {16'b0, smp.data};
      end else begin
        opb_req.be   = {lane_be, 2'b00};
        opb_req.dbus = smp.r_w_n ? '0 : {smp.data, 16'b0};
      end
    end
  end

  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ST_IDLE;
      select_q <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            select_q <= 1'b1;
            state    <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (!in_access || reply) begin  // host gave up, or slave answered
            select_q <= 1'b0;
            state    <= ST_IDLE;
          end
        end
        default: begin
          select_q <= 1'b0;
          state    <= ST_IDLE;
        end
      endcase
    end
  end

  // a reply after the host released cs_n is dropped
  assign rdy_int = (state == ST_WAIT) & reply & in_access;
  assign rd_half = smp.addr[0] ? opb_rsp.dbus[15:0] : opb_rsp.dbus[31:16];

  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      epb_rdy    <= 1'b0;
      epb_data_o <= '0;
    end else begin
      epb_rdy <= rdy_int;
      if (rdy_int) begin
        epb_data_o <= rd_half;  // held until the next ready
      end
    end
  end

endmodule

/* opb_addr_decode.sv */
`include "epb_opb_defines.svh"

module opb_addr_decode (
  input  epb_opb_pkg::opb_req_t opb_req,
  output epb_opb_pkg::opb_req_t slv_req [`EPB_OPB_NUM_SLAVES],
  output logic                  unmapped
);
  localparam int unsigned IDX_W  = $clog2(`EPB_OPB_NUM_SLAVES);
  localparam int unsigned HI_LSB = `EPB_OPB_SLAVE_IDX_LSB + IDX_W;

  logic [IDX_W-1:0] slv_idx;
  logic             in_map;

  assign slv_idx = opb_req.abus[HI_LSB-1:`EPB_OPB_SLAVE_IDX_LSB];

  // anything above the slave index field lies outside the map
  assign in_map   = (opb_req.abus[`EPB_OPB_DATA_W-1:HI_LSB] == '0);
  assign unmapped = opb_req.select & ~in_map;

  // only the matching slave sees the request, others get all zero
  always_comb begin
    for (int i = 0; i < `EPB_OPB_NUM_SLAVES; i++) begin
      if (in_map && slv_idx == IDX_W'(i)) begin
        slv_req[i] = opb_req;
      end else begin
        slv_req[i] = '0;
      end
    end
  end

endmodule

/* opb_reg_slave.sv */
`include "epb_opb_defines.svh"

module opb_reg_slave (
  input  logic                  OPB_Clk,
  input  logic                  arst_n,
  input  epb_opb_pkg::opb_req_t req,
  output epb_opb_pkg::opb_rsp_t rsp
);
  localparam int unsigned IDX_W   = $clog2(`EPB_OPB_SLAVE_WORDS);
  localparam int unsigned N_BYTES = `EPB_OPB_DATA_W / 8;

  logic [`EPB_OPB_DATA_W-1:0] regs [`EPB_OPB_SLAVE_WORDS];
  logic [`EPB_OPB_DATA_W-1:0] rdata_q;
  logic [IDX_W-1:0]           idx;
  logic                       access;
  logic                       ack_q;
  logic                       rd_q;

  assign idx    = req.abus[IDX_W+1:2];  // word index
  assign access = req.select & ~ack_q;  // no second ack for the same access

  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      ack_q <= 1'b0;
      rd_q  <= 1'b0;
      for (int w = 0; w < `EPB_OPB_SLAVE_WORDS; w++) begin
        regs[w] <= '0;
      end
    end else begin
      ack_q <= access;
      rd_q  <= access & req.rnw;
      if (access && !req.rnw) begin
        for (int b = 0; b < N_BYTES; b++) begin
          if (req.be[b]) begin
            regs[idx][8*b +: 8] <= req.dbus[8*b +: 8];
          end
        end
      end
    end
  end

  // read data captured with the select, shown only in the ack cycle
  always_ff @(posedge OPB_Clk) begin
    if (access && req.rnw) begin
      rdata_q <= regs[idx];
    end
  end

  assign rsp.xfer_ack = ack_q;
  assign rsp.err_ack  = 1'b0;  // every word is backed
  assign rsp.dbus     = rd_q ? rdata_q : '0;

endmodule

/* opb_reply_merge.sv */
`include "epb_opb_defines.svh"

module opb_reply_merge (
  input  logic                  OPB_Clk,
  input  logic                  arst_n,
  input  epb_opb_pkg::opb_rsp_t slv_rsp [`EPB_OPB_NUM_SLAVES],
  input  logic                  unmapped,
  output epb_opb_pkg::opb_rsp_t rsp
);
  import epb_opb_pkg::*;

  opb_rsp_t slv_or;
  logic     err_q;

  // idle slaves drive zeros, so a plain or is enough
  always_comb begin
    slv_or = '0;
    for (int i = 0; i < `EPB_OPB_NUM_SLAVES; i++) begin
      slv_or = slv_or | slv_rsp[i];
    end
  end

  // one err_ack a cycle after select, not repeated while select stays up
  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      err_q <= 1'b0;
    end else begin
      err_q <= unmapped & ~err_q;
    end
  end

  assign rsp.xfer_ack = slv_or.xfer_ack;
  assign rsp.err_ack  = slv_or.err_ack | err_q;
  assign rsp.dbus     = slv_or.dbus;  // error replies carry zero data

endmodule

/* epb_opb_sys.sv */
`include "epb_opb_defines.svh"

module epb_opb_sys (
  input  logic        OPB_Clk,
  input  logic        arst_n,
  input  logic        epb_cs_n,
  input  logic        epb_oe_n,
  input  logic        epb_r_w_n,
  input  logic [1:0]  epb_be_n,
  input  logic [22:0] epb_addr,
  input  logic [5:0]  epb_addr_gp,
  input  logic [15:0] epb_data_i,
  output logic [15:0] epb_data_o,
  output logic        epb_data_oe_n,
  output logic        epb_rdy
);
  import epb_opb_pkg::*;

  opb_req_t opb_req;
  opb_rsp_t opb_rsp;
  opb_req_t slv_req [`EPB_OPB_NUM_SLAVES];
  opb_rsp_t slv_rsp [`EPB_OPB_NUM_SLAVES];
  logic     unmapped;

  epb_opb_bridge u_bridge (
    .OPB_Clk       (OPB_Clk),
    .arst_n        (arst_n),
    .epb_cs_n      (epb_cs_n),
    .epb_oe_n      (epb_oe_n),
    .epb_r_w_n     (epb_r_w_n),
    .epb_be_n      (epb_be_n),
    .epb_addr      (epb_addr),
    .epb_addr_gp   (epb_addr_gp),
    .epb_data_i    (epb_data_i),
    .epb_data_o    (epb_data_o),
    .epb_data_oe_n (epb_data_oe_n),
    .epb_rdy       (epb_rdy),
    .opb_req       (opb_req),
    .opb_rsp       (opb_rsp)
  );

  opb_addr_decode u_decode (
    .opb_req  (opb_req),
    .slv_req  (slv_req),
    .unmapped (unmapped)
  );

  for (genvar i = 0; i < `EPB_OPB_NUM_SLAVES; i++) begin : g_slave
    opb_reg_slave u_slave (
      .OPB_Clk (OPB_Clk),
      .arst_n  (arst_n),
      .req     (slv_req[i]),
      .rsp     (slv_rsp[i])
    );
  end

  opb_reply_merge u_merge (
    .OPB_Clk  (OPB_Clk),
    .arst_n   (arst_n),
    .slv_rsp  (slv_rsp),
    .unmapped (unmapped),
    .rsp      (opb_rsp)
  );

endmodule

/* epb_opb_sys_properties.sv */
`include "epb_opb_defines.svh"

module epb_opb_sys_properties (
  input logic                  OPB_Clk,
  input logic                  arst_n,
  input logic                  epb_rdy,
  input epb_opb_pkg::opb_req_t opb_req,
  input epb_opb_pkg::opb_rsp_t opb_rsp,
  input epb_opb_pkg::opb_req_t slv_req [`EPB_OPB_NUM_SLAVES]
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [`EPB_OPB_NUM_SLAVES-1:0] sel_vec;

  always_comb begin
    for (int i = 0; i < `EPB_OPB_NUM_SLAVES; i++) begin
      sel_vec[i] = slv_req[i].select;
    end
  end

  rdy_pulse_a: assert property (@(posedge OPB_Clk) disable iff (!arst_n)
    epb_rdy |=> !epb_rdy) else $error("epb_rdy high two cycles running");

  // decoder routes to one slave at most
  one_slave_a: assert property (@(posedge OPB_Clk) disable iff (!arst_n)
    $onehot0(sel_vec)) else $error("more than one slave selected");

  ack_excl_a: assert property (@(posedge OPB_Clk) disable iff (!arst_n)
    !(opb_rsp.xfer_ack && opb_rsp.err_ack)) else $error("xfer_ack and err_ack together");

  rst_sel_a: assert property (@(posedge OPB_Clk)
    !arst_n |-> !opb_req.select) else $error("select high during reset");

endmodule

bind epb_opb_sys epb_opb_sys_properties props_i (
  .OPB_Clk (OPB_Clk),
  .arst_n  (arst_n),
  .epb_rdy (epb_rdy),
  .opb_req (opb_req),
  .opb_rsp (opb_rsp),
  .slv_req (slv_req)
);

/* tb_epb_opb_sys.sv */
module tb_epb_opb_sys;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic        wr;       // write when high
    logic        oe_n;
    logic [5:0]  gp;
    logic [22:0] addr;
    logic [1:0]  be_n;
    logic [15:0] wdata;
    logic [15:0] rdata;    // expected read data
    logic [2:0]  hold;     // 0 holds cs_n until epb_rdy
    logic        rdy_exp;
  } entry_t;

  localparam int N_ENTRIES = 22;
  localparam int TIMEOUT   = N_ENTRIES * 8 + 40;

  logic        OPB_Clk;
  logic        arst_n;
  logic        epb_cs_n;
  logic        epb_oe_n;
  logic        epb_r_w_n;
  logic [1:0]  epb_be_n;
  logic [22:0] epb_addr;
  logic [5:0]  epb_addr_gp;
  logic [15:0] epb_data_i;
  logic [15:0] epb_data_o;
  logic        epb_data_oe_n;
  logic        epb_rdy;
  entry_t      tbl [N_ENTRIES];
  int          cycle_cnt = 0;
  logic        pin_cs_n_q;   // host pins as seen on the last edge
  logic        pin_r_w_n_q;
  logic        pin_oe_n_q;

  epb_opb_sys dut_i (.*);

  always #50 OPB_Clk = ~OPB_Clk;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) else
      stop_on_error($sformatf("ERROR t=%0t %s expected %h got %h", $time, name, exp, act));
  endtask

  always @(posedge OPB_Clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      stop_on_error("timeout: the stimulus table did not finish in time");
    end
    pin_cs_n_q  <= epb_cs_n;
    pin_r_w_n_q <= epb_r_w_n;
    pin_oe_n_q  <= epb_oe_n;
  end

  // data pins turn around only for a selected read with oe_n low
  always @(negedge OPB_Clk) begin
    if (arst_n) begin
      check_val("epb_data_oe_n", 16'(!(!pin_cs_n_q && pin_r_w_n_q && !pin_oe_n_q)),
                16'(epb_data_oe_n));
    end
  end

  task automatic run_entry(input entry_t e);
    int edges;
    @(posedge OPB_Clk);
    epb_cs_n    <= 1'b0;
    epb_r_w_n   <= ~e.wr;
    epb_oe_n    <= e.oe_n;
    epb_be_n    <= e.be_n;
    epb_addr    <= e.addr;
    epb_addr_gp <= e.gp;
    epb_data_i  <= e.wdata;
    edges = 0;
    if (e.hold == 3'd0) begin
      do begin
        @(posedge OPB_Clk);
        edges++;
        @(negedge OPB_Clk);
      end while (!epb_rdy && edges < 8);
      check_val("epb_rdy", 16'(e.rdy_exp), 16'(epb_rdy));
      check_val("epb_rdy latency", 16'd3, 16'(edges));
      if (!e.wr) check_val("epb_data_o", e.rdata, epb_data_o);
      @(posedge OPB_Clk);
    end else begin
      repeat (e.hold) @(posedge OPB_Clk);
    end
    epb_cs_n <= 1'b1;  // release, stays high two cycles
    epb_oe_n <= 1'b1;
    if (e.hold == 3'd0) begin
      @(posedge OPB_Clk);
    end else begin
      repeat (6) begin  // abandoned access, no ready allowed
        @(posedge OPB_Clk);
        @(negedge OPB_Clk);
        check_val("epb_rdy", 16'(e.rdy_exp), 16'(epb_rdy));
      end
    end
  endtask

  initial begin
    OPB_Clk     = 1'b0;
    arst_n      = 1'b0;
    epb_cs_n    = 1'b1;
    epb_oe_n    = 1'b1;
    epb_r_w_n   = 1'b1;
    epb_be_n    = 2'b11;
    epb_addr    = '0;
    epb_addr_gp = '0;
    epb_data_i  = '0;
    // wr, oe_n, gp, addr, be_n, wdata, rdata, hold, rdy_exp
    tbl[0]  = '{1'b0, 1'b0, 6'h00, 23'h000000, 2'b00, 16'h0000, 16'h0000, 3'd0, 1'b1};
    tbl[1]  = '{1'b0, 1'b0, 6'h00, 23'h000001, 2'b00, 16'h0000, 16'h0000, 3'd0, 1'b1};
    tbl[2]  = '{1'b0, 1'b0, 6'h00, 23'h00003e, 2'b00, 16'h0000, 16'h0000, 3'd0, 1'b1};
    tbl[3]  = '{1'b0, 1'b0, 6'h00, 23'h00003f, 2'b00, 16'h0000, 16'h0000, 3'd0, 1'b1};
    tbl[4]  = '{1'b0, 1'b1, 6'h00, 23'h000012, 2'b00, 16'h0000, 16'h0000, 3'd0, 1'b1};
    tbl[5]  = '{1'b1, 1'b1, 6'h00, 23'h000014, 2'b00, 16'ha5c3, 16'h0000, 3'd0, 1'b1};
    tbl[6]  = '{1'b1, 1'b1, 6'h00, 23'h000015, 2'b00, 16'h1e7b, 16'h0000, 3'd0, 1'b1};
    tbl[7]  = '{1'b0, 1'b0, 6'h00, 23'h000014, 2'b00, 16'h0000, 16'ha5c3, 3'd0, 1'b1};
    tbl[8]  = '{1'b0, 1'b0, 6'h00, 23'h000015, 2'b00, 16'h0000, 16'h1e7b, 3'd0, 1'b1};
    tbl[9]  = '{1'b1, 1'b1, 6'h00, 23'h000014, 2'b10, 16'hff42, 16'h0000, 3'd0, 1'b1};
    tbl[10] = '{1'b0, 1'b0, 6'h00, 23'h000014, 2'b00, 16'h0000, 16'ha542, 3'd0, 1'b1};
    tbl[11] = '{1'b1, 1'b1, 6'h00, 23'h000015, 2'b01, 16'h9900, 16'h0000, 3'd0, 1'b1};
    tbl[12] = '{1'b0, 1'b0, 6'h00, 23'h000015, 2'b00, 16'h0000, 16'h997b, 3'd0, 1'b1};
    tbl[13] = '{1'b1, 1'b1, 6'h01, 23'h000014, 2'b00, 16'hdead, 16'h0000, 3'd0, 1'b1};
    tbl[14] = '{1'b0, 1'b0, 6'h01, 23'h000014, 2'b00, 16'h0000, 16'h0000, 3'd0, 1'b1};
    tbl[15] = '{1'b0, 1'b0, 6'h00, 23'h000014, 2'b00, 16'h0000, 16'ha542, 3'd0, 1'b1};
    tbl[16] = '{1'b0, 1'b0, 6'h00, 23'h000040, 2'b00, 16'h0000, 16'h0000, 3'd0, 1'b1};
    tbl[17] = '{1'b0, 1'b0, 6'h00, 23'h000015, 2'b00, 16'h0000, 16'h0000, 3'd1, 1'b0};
    tbl[18] = '{1'b0, 1'b0, 6'h00, 23'h000015, 2'b00, 16'h0000, 16'h997b, 3'd0, 1'b1};
    tbl[19] = '{1'b0, 1'b1, 6'h00, 23'h000015, 2'b00, 16'h0000, 16'h997b, 3'd0, 1'b1};
    tbl[20] = '{1'b1, 1'b0, 6'h00, 23'h00003f, 2'b00, 16'h0f0f, 16'h0000, 3'd0, 1'b1};
    tbl[21] = '{1'b0, 1'b0, 6'h00, 23'h00003f, 2'b00, 16'h0000, 16'h0f0f, 3'd0, 1'b1};
    repeat (16) @(posedge OPB_Clk);
    arst_n <= 1'b1;
    repeat (2) @(posedge OPB_Clk);
    foreach (tbl[i]) run_entry(tbl[i]);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* epb_opb_sys.f */
+incdir+.
epb_opb_pkg.sv
epb_opb_bridge.sv
opb_addr_decode.sv
opb_reg_slave.sv
opb_reply_merge.sv
epb_opb_sys.sv
epb_opb_sys_properties.sv
tb_epb_opb_sys.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_epb_opb_sys -f epb_opb_sys.f --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  echo "run passed"
else
  echo "run failed"
  exit 1
fi
